// ==== verilog.f ====
rtl/isa_pkg.sv
rtl/cpu_pkg.sv
rtl/run_control.sv
rtl/program_counter.sv
rtl/decoder.sv
rtl/register_file.sv
rtl/alu.sv
rtl/word_memory.sv
rtl/cpu_top.sv
test/tb_clock.sv
test/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cpu testbench with Verilator and run it

verilator --binary --timing --assert --top-module cpu_tb -f verilog.f -o cpu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/cpu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0

// ==== test/cpu_tb.sv ====
// cpu testbench: program builders, reference model, compare tasks, timeout
module cpu_tb;
    import isa_pkg::*;
    import cpu_pkg::*;

    logic clk, rst_gen, soft_rst, load_instr, load_dmem, start, done;
    logic [9:0] load_addr;
    word_t load_data, dbg_data;
    reg_addr_t dbg_addr;
    logic [31:0] seed = 32'he064_c777;
    int cycles = 0;
    int cycle_limit = 205; // margin plus power-on reset
    word_t prog[$];
    word_t m_regs [32];
    word_t m_imem [1024];
    word_t m_dmem [1024];

    tb_clock u_clk (.clk(clk), .rst(rst_gen));

    cpu_top #(.addr_w(10)) UUT (
        .clk(clk), .rst(rst_gen || soft_rst), .load_addr(load_addr), .load_data(load_data),
        .load_instr(load_instr), .load_dmem(load_dmem), .start(start),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data), .done(done)
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Done: errors found");
            $fatal(1, "timeout: the run went past %0d cycles", cycle_limit);
        end
    end

    function automatic word_t next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic word_t enc_r(int fn, int rd, int rs, int rt, int sh);
        return {op_rtype, 5'(rd), 5'(rt), 5'(rs), 5'(sh), 6'(fn)};
    endfunction

    function automatic word_t enc_i(opcode_t op, int rd, int rt, int imm);
        return {op, 5'(rd), 5'(rt), 16'(imm)};
    endfunction

    // executes m_imem from address 0 until halt, returns cycles used
    function automatic int run_model();
        instr_t ins;
        word_t x, y, imm, res;
        logic signed [63:0] prod;
        logic [9:0] pc, nxt;
        logic wr, take;
        int steps;
        pc = '0;
        steps = 0;
        ins = m_imem[pc];
        while (ins.opcode != op_halt && steps < 5000) begin
            imm = {{16{ins[15]}}, ins[15:0]};
            x = (ins.opcode inside {op_sw, op_beq, op_bne, op_bgt, op_bge, op_blt, op_ble})
                ? m_regs[ins.rd] : m_regs[ins.rs];
            y = m_regs[ins.rt];
            prod = longint'(signed'(x)) * longint'(signed'(y));
            nxt = pc + 10'd1;
            wr = 1'b1;
            take = 1'b0;
            res = '0;
            case (ins.opcode)
                op_rtype: begin
                    case (ins.func)
                        fn_add:  res = x + y;
                        fn_sub:  res = x - y;
                        fn_and:  res = x & y;
                        fn_or:   res = x | y;
                        fn_not:  res = ~x;
                        fn_xor:  res = x ^ y;
                        fn_slt:  res = {31'd0, signed'(x) < signed'(y)};
                        fn_sll:  res = x << ins.shamt;
                        fn_srl:  res = x >> ins.shamt;
                        fn_mulh: res = prod[63:32];
                        fn_mull: res = prod[31:0];
                        default: wr = 1'b0; // unknown function writes nothing
                    endcase
                end
                op_addi: res = x + imm;
                op_andi: res = x & imm;
                op_ori:  res = x | imm;
                op_xori: res = x ^ imm;
                op_slti: res = {31'd0, signed'(x) < signed'(imm)};
                op_seqi: res = {31'd0, x == imm};
                op_lui:  res = {imm[15:0], 16'd0};
                op_lw:   res = m_dmem[10'(x + imm)];
                op_sw: begin
                    m_dmem[10'(x + imm)] = y;
                    wr = 1'b0;
                end
                op_beq, op_bne, op_bgt, op_bge, op_blt, op_ble: begin
                    wr = 1'b0;
                    case (ins.opcode)
                        op_beq:  take = (x == y);
                        op_bne:  take = (x != y);
                        op_bgt:  take = signed'(x) > signed'(y);
                        op_bge:  take = signed'(x) >= signed'(y);
                        op_blt:  take = signed'(x) < signed'(y);
                        default: take = signed'(x) <= signed'(y);
                    endcase
                    if (take) nxt = nxt + imm[9:0]; // relative to next instruction
                end
                op_j: begin
                    wr = 1'b0;
                    nxt = ins[9:0];
                end
                op_jal: begin
                    res = {22'd0, nxt};
                    nxt = ins[9:0];
                end
                default: wr = 1'b0;
            endcase
            if (wr) m_regs[(ins.opcode == op_jal) ? link_reg : ins.rd] = res;
            pc = nxt;
            steps++;
            ins = m_imem[pc];
        end
        return steps + 1; // halt fetch takes one more edge
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_state(input string name, input run_state_t exp, input run_state_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %s actual %s", name, exp.name(), act.name());
            $display("Done: errors found");
            $fatal(1, "state mismatch");
        end
    endtask

    task automatic check_regs(input string name);
        cycle_limit += 32;
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            #2 dbg_addr = 5'(i);
            #10 check_word($sformatf("%s r%0d", name, i), m_regs[i], dbg_data);
        end
    endtask

    task automatic pulse_reset();
        cycle_limit += 7;
        @(posedge clk);
        #2 soft_rst = 1'b1;
        repeat (5) @(posedge clk);
        #2 soft_rst = 1'b0;
        for (int i = 0; i < 32; i++) m_regs[i] = '0;
        prog.delete();
    endtask

    task automatic load_word(input logic to_imem, input int addr, input word_t data);
        cycle_limit += 1;
        @(posedge clk);
        #2;
        load_addr = 10'(addr);
        load_data = data;
        load_instr = to_imem;
        load_dmem = !to_imem;
        if (to_imem) m_imem[addr] = data;
        else m_dmem[addr] = data;
    endtask

    // pulse start, then poll done once per cycle
    task automatic start_and_wait(input string name);
        cycle_limit += 2 + run_model();
        @(posedge clk);
        #2;
        load_instr = 1'b0;
        load_dmem = 1'b0;
        start = 1'b1;
        @(posedge clk);
        #2 start = 1'b0;
        check_state(name, st_running, UUT.u_run.state);
        while (!done) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic run_program(input string name);
        for (int i = 0; i < prog.size(); i++) load_word(1'b1, i, prog[i]);
        start_and_wait(name);
        check_regs(name);
    endtask

    task automatic random_program(input int n);
        func_t fns [11] = '{fn_add, fn_sub, fn_and, fn_or, fn_not, fn_xor,
                            fn_slt, fn_sll, fn_srl, fn_mulh, fn_mull};
        opcode_t ops [7] = '{op_addi, op_andi, op_ori, op_xori, op_slti, op_seqi, op_lui};
        word_t r, v;
        for (int i = 0; i < n; i++) begin
            r = next_rand();
            v = next_rand();
            if (r[31:28] < 4'd8) begin
                prog.push_back(enc_r(fns[int'(r[27:24]) % 11], r[5:1], r[15:11], r[10:6],
                                     r[20:16]));
            end else begin
                prog.push_back(enc_i(ops[int'(r[27:24]) % 7], r[5:1], r[10:6], v[15:0]));
            end
        end
        prog.push_back({op_halt, 26'd0});
    endtask

    initial begin
        opcode_t bops [12] = '{op_beq, op_beq, op_bne, op_bne, op_bgt, op_bgt,
                               op_bge, op_bge, op_blt, op_blt, op_ble, op_ble};
        int ra [12] = '{4, 4, 4, 4, 5, 4, 4, 4, 4, 5, 4, 5};
        int rb [12] = '{4, 5, 5, 4, 4, 5, 4, 5, 5, 4, 4, 4};
        int jal_at;
        soft_rst = 1'b0;
        load_instr = 1'b0;
        load_dmem = 1'b0;
        load_addr = '0;
        load_data = '0;
        start = 1'b0;
        dbg_addr = '0;
        for (int i = 0; i < 32; i++) m_regs[i] = '0;
        for (int i = 0; i < 1024; i++) begin
            m_imem[i] = '0;
            m_dmem[i] = '0;
        end
        wait (rst_gen === 1'b0);
        #2 check_word("done after reset", '0, {31'd0, done});
        check_state("state after reset", st_loading, UUT.u_run.state);
        check_regs("reset");

        for (int t = 0; t < 3; t++) begin
            pulse_reset();
            random_program(40);
            run_program($sformatf("random %0d", t));
        end

        pulse_reset();
        load_word(1'b0, 100, 32'h1234_5678);
        load_word(1'b0, 101, 32'hcafe_0042);
        prog = '{enc_i(op_addi, 1, 0, 200), enc_i(op_addi, 2, 0, 77),
                 enc_i(op_lui, 4, 0, 16'h8001), enc_r(fn_add, 5, 4, 2, 0),
                 enc_i(op_sw, 1, 2, 0), enc_i(op_sw, 1, 4, 1), enc_i(op_sw, 1, 5, 5),
                 enc_i(op_lw, 6, 0, 200), enc_i(op_lw, 7, 0, 201), enc_i(op_lw, 8, 0, 205),
                 enc_i(op_lw, 9, 0, 100), enc_i(op_lw, 10, 0, 101), {op_halt, 26'd0}};
        run_program("memory");

        pulse_reset();
        prog = '{enc_i(op_addi, 10, 0, 1), enc_i(op_addi, 1, 0, 5),
                 enc_r(fn_sub, 1, 1, 10, 0), enc_r(fn_add, 2, 2, 10, 0),
                 enc_i(op_bne, 1, 0, -3), enc_i(op_addi, 11, 0, 3),
                 enc_r(fn_sub, 11, 11, 10, 0), enc_r(fn_add, 12, 12, 10, 0),
                 enc_i(op_blt, 0, 11, -3), enc_i(op_addi, 4, 0, 5), enc_i(op_addi, 5, 0, 9)};
        for (int i = 0; i < 12; i++) begin
            prog.push_back(enc_i(bops[i], ra[i], rb[i], 1));
            prog.push_back(enc_i(op_addi, 15 + i, 0, i + 1)); // skipped when taken
        end
        prog.push_back({op_j, 26'(prog.size() + 2)});
        prog.push_back(enc_i(op_addi, 27, 0, 16'h66));
        jal_at = prog.size();
        prog.push_back({op_jal, 26'(jal_at + 2)});
        prog.push_back(enc_i(op_addi, 28, 0, 16'h77));
        prog.push_back({op_halt, 26'd0});
        run_program("control");
        cycle_limit += 1;
        @(posedge clk);
        #2 dbg_addr = link_reg;
        #10 check_word("jal link", word_t'(jal_at + 1), dbg_data);

        pulse_reset();
        prog = '{enc_i(op_addi, 5, 0, 3), enc_r(fn_add, 6, 6, 5, 0), {op_halt, 26'd0},
                 enc_i(op_addi, 7, 0, 16'h55)};
        run_program("halt first run");
        cycle_limit += 5;
        repeat (5) @(posedge clk);
        #2 check_word("done held", 32'd1, {31'd0, done});
        start_and_wait("halt second run");
        check_regs("halt second run");

        $display("Done: no errors");
        $finish;
    end
endmodule

// ==== test/tb_clock.sv ====
// testbench clock and power-on reset generator
module tb_clock (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // period 20
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;
    end
endmodule

// ==== rtl/cpu_top.sv ====
// single-cycle processor top: instances, operand and writeback muxes, load port steering
module cpu_top #(
    parameter int addr_w = 10
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [addr_w-1:0]  load_addr,
    input  cpu_pkg::word_t     load_data,
    input  logic               load_instr,
    input  logic               load_dmem,
    input  logic               start,
    input  cpu_pkg::reg_addr_t dbg_addr,
    output cpu_pkg::word_t     dbg_data,
    output logic               done
);
    import isa_pkg::*;
    import cpu_pkg::*;

    logic              running, loading;
    logic [addr_w-1:0] pc, pc_next_seq;
    word_t             imem_data, dmem_data, reg_a, reg_b, alu_y, alu_result, wb_data, imm_ext;
    instr_t            instr;
    ctrl_t             ctrl;
    alu_op_t           alu_op;
    reg_addr_t         dst, src_a;

    assign loading = !running && !done;
    assign instr   = instr_t'(imem_data);
    assign imm_ext = {{16{instr.rs[4]}}, instr[15:0]};
    assign alu_y   = ctrl.use_imm ? imm_ext : reg_b;

    always_comb begin
        if (ctrl.link) wb_data = {{(32 - addr_w){1'b0}}, pc_next_seq};
        else if (ctrl.mem_to_reg) wb_data = dmem_data;
        else wb_data = alu_result;
    end

    run_control u_run (
        .clk(clk), .rst(rst), .start(start), .halt_seen(ctrl.halt),
        .running(running), .done(done)
    );

    program_counter #(.addr_w(addr_w)) u_pc (
        .clk(clk), .rst(rst), .step(running && !ctrl.halt), .restart(start && done),
        .take_branch(ctrl.branch && alu_result[0]), .offset(instr[15:0]),
        .jump(ctrl.jump), .target(instr[25:0]), .pc(pc), .pc_next_seq(pc_next_seq)
    );

    decoder u_dec (.instr(instr), .ctrl(ctrl), .alu_op(alu_op), .dst(dst), .src_a(src_a));

    register_file u_rf (
        .clk(clk), .rst(rst), .we(running && ctrl.reg_write), .wr_addr(dst),
        .wr_data(wb_data), .rd_a(src_a), .rd_b(instr.rt), .a(reg_a), .b(reg_b),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

    alu u_alu (.op(alu_op), .x(reg_a), .y(alu_y), .shamt(instr.shamt), .result(alu_result));

    word_memory #(.addr_w(addr_w)) u_imem (
        .clk(clk), .we(loading && load_instr), .wr_addr(load_addr), .wr_data(load_data),
        .rd_addr(pc), .rd_data(imem_data)
    );

    // load port owns the data memory while loading, sw while running
    word_memory #(.addr_w(addr_w)) u_dmem (
        .clk(clk),
        .we(loading ? load_dmem : (running && ctrl.mem_write)),
        .wr_addr(loading ? load_addr : alu_result[addr_w-1:0]),
        .wr_data(loading ? load_data : reg_b),
        .rd_addr(alu_result[addr_w-1:0]), .rd_data(dmem_data)
    );

endmodule

// ==== rtl/word_memory.sv ====
// word-addressed memory, combinational read, write on rising edge
module word_memory #(
    parameter int addr_w = 10
) (
    input  logic              clk,
    input  logic              we,
    input  logic [addr_w-1:0] wr_addr,
    input  cpu_pkg::word_t    wr_data,
    input  logic [addr_w-1:0] rd_addr,
    output cpu_pkg::word_t    rd_data
);
    import cpu_pkg::*;

    word_t mem [2**addr_w];

    initial begin
        for (int i = 0; i < 2**addr_w; i++) begin
            mem[i] = '0; // contents start cleared
        end
    end

    always_ff @(posedge clk) begin
        if (we) mem[wr_addr] <= wr_data;
    end

    assign rd_data = mem[rd_addr];

endmodule

// ==== rtl/alu.sv ====
// integer alu: arithmetic, logic, shifts, signed compares, multiply
module alu (
    input  isa_pkg::alu_op_t op,
    input  cpu_pkg::word_t   x,
    input  cpu_pkg::word_t   y,
    input  cpu_pkg::shamt_t  shamt,
    output cpu_pkg::word_t   result
);
    import isa_pkg::*;
    import cpu_pkg::*;

    logic signed [63:0] product;

    assign product = $signed(x) * $signed(y);

    always_comb begin
        case (op)
            alu_add:  result = x + y;
            alu_sub:  result = x - y;
            alu_and:  result = x & y;
            alu_xor:  result = x ^ y;
            alu_or:   result = x | y;
            alu_not:  result = ~x;
            alu_sll:  result = x << shamt;
            alu_srl:  result = x >> shamt; // logical
            alu_sne:  result = word_t'(x != y);
            alu_seq:  result = word_t'(x == y);
            alu_slt:  result = word_t'($signed(x) < $signed(y));
            alu_sle:  result = word_t'($signed(x) <= $signed(y));
            alu_sgt:  result = word_t'($signed(x) > $signed(y));
            alu_sge:  result = word_t'($signed(x) >= $signed(y));
            alu_lui:  result = y << 16;
            alu_mull: result = product[31:0];
            alu_mulh: result = product[63:32];
            default:  result = 32'hdead_beef;
        endcase
    end

endmodule

// ==== rtl/register_file.sv ====
// 32 x 32 register file, two read ports, one write port, debug read port
module register_file (
    input  logic               clk,
    input  logic               rst,
    input  logic               we,
    input  cpu_pkg::reg_addr_t wr_addr,
    input  cpu_pkg::word_t     wr_data,
    input  cpu_pkg::reg_addr_t rd_a,
    input  cpu_pkg::reg_addr_t rd_b,
    output cpu_pkg::word_t     a,
    output cpu_pkg::word_t     b,
    input  cpu_pkg::reg_addr_t dbg_addr,
    output cpu_pkg::word_t     dbg_data
);
    import cpu_pkg::*;

    word_t regs [32]; // r0 is an ordinary register

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign a        = regs[rd_a];
    assign b        = regs[rd_b];
    assign dbg_data = regs[dbg_addr];

    // write enable comes from run control, which sits in loading after reset
    no_wr_after_rst_a: assert property (@(posedge clk) rst |=> !we);

endmodule

// ==== rtl/decoder.sv ====
// instruction decoder: control bits, alu operation, register selection
module decoder (
    input  isa_pkg::instr_t    instr,
    output cpu_pkg::ctrl_t     ctrl,
    output isa_pkg::alu_op_t   alu_op,
    output cpu_pkg::reg_addr_t dst,
    output cpu_pkg::reg_addr_t src_a
);
    import isa_pkg::*;

    logic fn_ok; // known function code

    always_comb begin
        fn_ok = 1'b1;
        case (instr.func)
            fn_add:  alu_op = alu_add;
            fn_sub:  alu_op = alu_sub;
            fn_and:  alu_op = alu_and;
            fn_or:   alu_op = alu_or;
            fn_not:  alu_op = alu_not;
            fn_xor:  alu_op = alu_xor;
            fn_slt:  alu_op = alu_slt;
            fn_sll:  alu_op = alu_sll;
            fn_srl:  alu_op = alu_srl;
            fn_mulh: alu_op = alu_mulh;
            fn_mull: alu_op = alu_mull;
            default: begin
                alu_op = alu_add;
                fn_ok  = 1'b0;
            end
        endcase

        ctrl = '0;
        case (instr.opcode)
            op_rtype: ctrl.reg_write = fn_ok;
            op_addi, op_andi, op_ori, op_xori, op_slti, op_seqi, op_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            op_lw: begin
                ctrl.reg_write  = 1'b1;
                ctrl.use_imm    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            op_sw: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            op_beq, op_bne, op_bgt, op_bge, op_blt, op_ble: ctrl.branch = 1'b1;
            op_j:    ctrl.jump = 1'b1;
            op_jal: begin
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_halt: ctrl.halt = 1'b1;
            default: ctrl = '0; // unknown opcode does nothing
        endcase

        // immediate and branch forms override the function code
        case (instr.opcode)
            op_addi, op_lw, op_sw: alu_op = alu_add;
            op_andi:         alu_op = alu_and;
            op_ori:          alu_op = alu_or;
            op_xori:         alu_op = alu_xor;
            op_slti, op_blt: alu_op = alu_slt;
            op_seqi, op_beq: alu_op = alu_seq;
            op_lui:          alu_op = alu_lui;
            op_bne:          alu_op = alu_sne;
            op_bgt:          alu_op = alu_sgt;
            op_bge:          alu_op = alu_sge;
            op_ble:          alu_op = alu_sle;
            default: ;
        endcase
    end

    assign dst   = (instr.opcode == op_jal) ? link_reg : instr.rd;
    assign src_a = (ctrl.branch || ctrl.mem_write) ? instr.rd : instr.rs;

endmodule

// ==== rtl/program_counter.sv ====
// program counter with sequential step, branch, jump, hold and restart
module program_counter #(
    parameter int addr_w = 10
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              step,
    input  logic              restart,
    input  logic              take_branch,
    input  logic [15:0]       offset,
    input  logic              jump,
    input  logic [25:0]       target,
    output logic [addr_w-1:0] pc,
    output logic [addr_w-1:0] pc_next_seq
);
    logic [addr_w-1:0] pc_step;

    assign pc_next_seq = pc + addr_w'(1);

    // offset wraps modulo the address space
    always_comb begin
        if (jump) begin
            pc_step = target[addr_w-1:0];
        end else if (take_branch) begin
            pc_step = pc_next_seq + offset[addr_w-1:0];
        end else begin
            pc_step = pc_next_seq;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            pc <= '0;
        end else if (step) begin
            pc <= pc_step;
        end
    end

    // a taken branch and a jump never arrive together
    pc_redirect_excl_a: assert property (@(posedge clk) disable iff (rst)
        !(jump && take_branch));

endmodule

// ==== rtl/run_control.sv ====
// load/run/halt state machine
module run_control (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic halt_seen,
    output logic running,
    output logic done
);
    import cpu_pkg::*;

    run_state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_loading;
        end else begin
            case (state)
                st_loading: if (start) state <= st_running;
                st_running: if (halt_seen) state <= st_halted;
                st_halted:  if (start) state <= st_running; // rerun, registers kept
                default:    state <= st_loading;
            endcase
        end
    end

    assign running = (state == st_running);
    assign done    = (state == st_halted);

    // start arrives as a single-cycle pulse
    start_pulse_a: assert property (@(posedge clk) disable iff (rst) start |=> !start);

endmodule

// ==== rtl/cpu_pkg.sv ====
// datapath types: word, register address, shift amount, control bits, run states
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;

    typedef struct packed {
        logic reg_write;
        logic mem_write;
        logic use_imm;    // second operand from sign-extended immediate
        logic mem_to_reg; // writeback from data memory
        logic branch;
        logic jump;
        logic link;       // jal, write pc+1 to link register
        logic halt;
    } ctrl_t;

    typedef enum logic [1:0] {
        st_loading = 2'd0,
        st_running = 2'd1,
        st_halted  = 2'd2
    } run_state_t;

endpackage

// ==== rtl/isa_pkg.sv ====
// instruction set: opcodes, function codes, field layout, alu operations, link register
package isa_pkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] func_t;

    // rd is the destination field, rt the second, rs the third
    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rd;
        logic [4:0] rt;
        logic [4:0] rs;
        logic [4:0] shamt;
        func_t      func;
    } instr_t;

    typedef enum logic [4:0] {
        alu_add  = 5'd0,
        alu_sub  = 5'd1,
        alu_and  = 5'd2,
        alu_xor  = 5'd3,
        alu_or   = 5'd4,
        alu_not  = 5'd5,
        alu_sll  = 5'd6,
        alu_srl  = 5'd7,
        alu_sne  = 5'd8,
        alu_seq  = 5'd9,
        alu_slt  = 5'd10,
        alu_sle  = 5'd11,
        alu_sgt  = 5'd12,
        alu_sge  = 5'd13,
        alu_lui  = 5'd14,
        alu_mull = 5'd15,
        alu_mulh = 5'd16
    } alu_op_t;

    localparam opcode_t op_rtype = 6'd0;
    localparam opcode_t op_addi  = 6'd1;
    localparam opcode_t op_andi  = 6'd2;
    localparam opcode_t op_ori   = 6'd3;
    localparam opcode_t op_xori  = 6'd4;
    localparam opcode_t op_lw    = 6'd7;
    localparam opcode_t op_sw    = 6'd8;
    localparam opcode_t op_slti  = 6'd9;
    localparam opcode_t op_seqi  = 6'd10;
    localparam opcode_t op_lui   = 6'd11;
    localparam opcode_t op_beq   = 6'd16;
    localparam opcode_t op_bne   = 6'd17;
    localparam opcode_t op_bgt   = 6'd18;
    localparam opcode_t op_bge   = 6'd19;
    localparam opcode_t op_blt   = 6'd20;
    localparam opcode_t op_ble   = 6'd21;
    localparam opcode_t op_j     = 6'd24;
    localparam opcode_t op_jal   = 6'd26;
    localparam opcode_t op_halt  = 6'd63;

    localparam func_t fn_add  = 6'd0;
    localparam func_t fn_sub  = 6'd1;
    localparam func_t fn_and  = 6'd2;
    localparam func_t fn_or   = 6'd3;
    localparam func_t fn_not  = 6'd4;
    localparam func_t fn_xor  = 6'd5;
    localparam func_t fn_slt  = 6'd8;
    localparam func_t fn_sll  = 6'd9;
    localparam func_t fn_srl  = 6'd10;
    localparam func_t fn_mulh = 6'd11;
    localparam func_t fn_mull = 6'd12;

    localparam logic [4:0] link_reg = 5'd3; // jal return address

endpackage
